// File: Makefile
TOP := tb_mem_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: project.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_req_if.sv
verilog/fill_if.sv
verilog/apb_mem_port.sv
verilog/line_memory.sv
verilog/fill_buffer.sv
verilog/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// File: tb/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_subsys;

  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT_NS = 6 * 400 * CLK_PERIOD;  // Six tests of 400 cycles each.

  logic        pclk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] model [64];  // Shadow copy of the word array.
  logic [5:0]  model_addr;  // Expected address register.
  integer      seed;

  mem_subsys_top UUT (.*);

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired: the tests did not finish within %0d ns.", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped by the watchdog.");
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  task automatic check_err(input logic err, input logic expected);
    check("pslverr", {31'd0, err}, {31'd0, expected});
  endtask

  // One APB transfer with a setup and an access phase, sampled mid-cycle.
  // Every call starts just after a rising edge, so transfers run back to back.
  task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
    psel   = 1'b1;
    pwrite = wr;
    paddr  = addr;
    pwdata = data;
    @(posedge pclk);
    #1;
    penable = 1'b1;
    #5;
    rdata = prdata;
    err   = pslverr;
    check("pready", {31'd0, pready}, 32'd1);  // The slave never inserts wait states.
    @(posedge pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] ignored;
    apb_transfer(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
    apb_transfer(1'b0, addr, 32'd0, rdata, err);
  endtask

  task automatic set_addr(input logic [5:0] a);
    logic err;
    apb_write(`REG_ADDR, {26'd0, a}, err);
    check_err(err, 1'b0);
    model_addr = a;
  endtask

  task automatic store_word(input logic [31:0] data);
    logic err;
    apb_write(`REG_STORE, data, err);
    check_err(err, 1'b0);
    model[model_addr] = data;
    model_addr = model_addr + 6'd1;  // Wraps from 63 to 0 like the address register.
  endtask

  task automatic request_fill();
    logic err;
    apb_write(`REG_FILL, 32'd0, err);
    check_err(err, 1'b0);
  endtask

  task automatic wait_fill();
    logic [31:0] status;
    logic        err;
    int          polls;
    polls  = 0;
    status = 32'd0;
    while (status[1:0] != 2'b10) begin
      if (polls == 20) begin
        $display("Fill did not complete within 20 STATUS reads.");
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping on a fill that never finished.");
      end else begin
        apb_read(`REG_STATUS, status, err);
        polls++;
      end
    end
  endtask

  function automatic logic [3:0][31:0] model_line(input logic [3:0] line);
    logic [3:0][31:0] words;
    for (int w = 0; w < 4; w++) words[w] = model[{line, w[1:0]}];
    return words;
  endfunction

  task automatic compare_line(input logic [3:0] line, input logic [3:0][31:0] exp_words);
    logic [31:0] rdata;
    logic        err;
    for (int w = 0; w < 4; w++) begin
      apb_read(`REG_FILL_WORD0 + 8'(4 * w), rdata, err);
      check($sformatf("fill_word%0d", w), rdata, exp_words[w]);
    end
    apb_read(`REG_STATUS, rdata, err);
    check("status", rdata, {20'd0, line, 8'd2});  // Done set, busy clear.
  endtask

  task automatic fill_and_compare(input logic [5:0] a);
    set_addr(a);
    request_fill();
    wait_fill();
    compare_line(a[5:2], model_line(a[5:2]));
  endtask

  task automatic test_reset();
    logic [31:0] rdata;
    logic        err;
    apb_read(`REG_STATUS, rdata, err);
    check_err(err, 1'b0);
    check("status", rdata, 32'd0);
    for (int w = 0; w < 4; w++) begin
      apb_read(`REG_FILL_WORD0 + 8'(4 * w), rdata, err);
      check($sformatf("fill_word%0d", w), rdata, 32'd0);
    end
  endtask

  task automatic test_store_fill();
    logic [31:0] rdata;
    logic        err;
    set_addr(6'd8);
    repeat (4) store_word($random(seed));
    fill_and_compare(6'd9);
    apb_read(`REG_ADDR, rdata, err);
    check("addr", rdata, 32'd9);  // A fill leaves the address alone.
  endtask

  task automatic test_single_word();
    set_addr(6'd10);
    store_word($random(seed));
    fill_and_compare(6'd8);
  endtask

  task automatic test_fill_busy();
    logic [3:0][31:0] old_words;
    logic             err;
    set_addr(6'd8);
    old_words = model_line(4'd2);
    request_fill();
    apb_write(`REG_FILL, 32'd0, err);
    check_err(err, 1'b1);
    store_word($random(seed));  // Same line, written before the line comes back.
    wait_fill();
    compare_line(4'd2, old_words);
    fill_and_compare(6'd9);
  endtask

  task automatic test_wrap();
    logic [31:0] rdata;
    logic        err;
    set_addr(6'd60);
    repeat (8) store_word($random(seed));  // Words 60 to 63, then 0 to 3.
    apb_read(`REG_ADDR, rdata, err);
    check("addr", rdata, 32'd4);
    fill_and_compare(6'd0);
    fill_and_compare(6'd63);
  endtask

  task automatic test_access_errors();
    logic [31:0] rdata;
    logic        err;
    apb_read(8'h20, rdata, err);
    check_err(err, 1'b1);
    apb_write(8'h20, 32'hFFFF_FFFF, err);
    check_err(err, 1'b1);
    apb_read(`REG_STORE, rdata, err);
    check_err(err, 1'b1);
    apb_write(`REG_STATUS, 32'hFFFF_FFFF, err);
    check_err(err, 1'b1);
    apb_read(`REG_STATUS, rdata, err);
    check("status", rdata, {20'd0, 4'd15, 8'd2});  // Still the capture of line 15.
  endtask

  initial begin
    seed       = 32'h50e2_853a;
    model_addr = 6'd0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 8'd0;
    pwdata     = 32'd0;
    repeat (4) @(posedge pclk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_store_fill();
    test_single_word();
    test_fill_busy();
    test_wrap();
    test_access_errors();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/apb_mem_port.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module apb_mem_port import mem_pkg::*; (
  input  logic                       pclk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr,
  input  logic [`MEM_WORD_WIDTH-1:0] pwdata,
  output logic [`MEM_WORD_WIDTH-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  mem_req_if.master                  req,
  fill_if.status                     stat
);

  reg_sel_t                   sel;
  logic                       access;
  logic                       err;
  logic                       fill_pending;
  logic                       wr_ok;
  logic                       store_go;
  logic                       fill_go;
  logic [`MEM_ADDR_WIDTH-1:0] addr_reg;
  logic                       req_q;
  mem_op_t                    op_q;
  logic [`MEM_ADDR_WIDTH-1:0] addr_q;
  logic [`MEM_WORD_WIDTH-1:0] data_q;
  logic [`MEM_WORD_WIDTH-1:0] status_word;
  logic [`MEM_WORD_WIDTH-1:0] rd_data;

  assign access = psel && penable;  // APB access phase.
  assign pready = 1'b1;             // No wait states.

  always_comb begin
    if ({paddr[`APB_ADDR_WIDTH-1:4], 2'b00, paddr[1:0]} == `REG_FILL_WORD0) sel = SEL_FILL_WORD;
    else if (paddr == `REG_ADDR) sel = SEL_ADDR;
    else if (paddr == `REG_STORE) sel = SEL_STORE;
    else if (paddr == `REG_FILL) sel = SEL_FILL;
    else if (paddr == `REG_STATUS) sel = SEL_STATUS;
    else sel = SEL_NONE;
  end

  // A fill counts as outstanding from the cycle its request is in flight.
  assign fill_pending = stat.busy || (req_q && op_q == MEM_OP_FILL);

  always_comb begin
    case (sel)
      SEL_ADDR:      err = 1'b0;
      SEL_STORE:     err = !pwrite;                   // Write-only.
      SEL_FILL:      err = !pwrite || fill_pending;   // Rejected rather than queued.
      SEL_STATUS:    err = pwrite;                    // Read-only.
      SEL_FILL_WORD: err = pwrite;
      default:       err = 1'b1;
    endcase
  end

  assign pslverr  = access && err;
  assign wr_ok    = access && pwrite && !err;
  assign store_go = wr_ok && (sel == SEL_STORE);
  assign fill_go  = wr_ok && (sel == SEL_FILL);

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      req_q    <= 1'b0;
      op_q     <= MEM_OP_STORE;
      addr_reg <= '0;
    end else begin
      req_q <= store_go || fill_go;  // One pulse per accepted command.
      if (store_go || fill_go) op_q <= fill_go ? MEM_OP_FILL : MEM_OP_STORE;
      if (wr_ok && sel == SEL_ADDR) addr_reg <= pwdata[`MEM_ADDR_WIDTH-1:0];
      else if (store_go) addr_reg <= addr_reg + 1'b1;  // Wraps from 63 to 0.
    end
  end

  always_ff @(posedge pclk) begin
    if (store_go || fill_go) begin
      addr_q <= addr_reg;  // Address before the increment.
      data_q <= pwdata;
    end
  end

  assign req.req        = req_q;
  assign req.op         = op_q;
  assign req.addr       = addr_q;
  assign req.store_data = data_q;

  always_comb begin
    status_word       = '0;
    status_word[0]    = stat.busy;
    status_word[1]    = stat.done;
    status_word[11:8] = stat.cap_line;
  end

  always_comb begin
    rd_data = '0;
    case (sel)
      SEL_ADDR:      rd_data[`MEM_ADDR_WIDTH-1:0] = addr_reg;
      SEL_STATUS:    rd_data = status_word;
      SEL_FILL_WORD: rd_data = stat.fill_words[paddr[3:2]];
      default:       rd_data = '0;
    endcase
  end

  assign prdata = (access && !pwrite && !err) ? rd_data : '0;

endmodule

// File: verilog/fill_buffer.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module fill_buffer import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  mem_req_if.monitor  mon,
  fill_if.sink        fill
);

  logic                                            fill_start;
  logic                                            busy_q;
  logic                                            done_q;
  logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_WIDTH-1:0] words_q;
  logic [`MEM_LINE_IDX_WIDTH-1:0]                  line_q;

  assign fill_start = mon.req && (mon.op == MEM_OP_FILL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (fill_start) begin
      busy_q <= 1'b1;  // A new fill wins over a line arriving in the same cycle.
      done_q <= 1'b0;
    end else if (fill.fill_valid) begin
      busy_q <= 1'b0;
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      words_q <= '0;
      line_q  <= '0;
    end else if (fill.fill_valid) begin
      for (int w = 0; w < `MEM_LINE_WORDS; w++) begin
        words_q[w] <= fill.fill_data[w*`MEM_WORD_WIDTH +: `MEM_WORD_WIDTH];
      end
      line_q <= fill.fill_line;
    end
  end

  assign fill.busy       = busy_q;
  assign fill.done       = done_q;
  assign fill.fill_words = words_q;
  assign fill.cap_line   = line_q;

endmodule

// File: verilog/fill_if.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

interface fill_if ();

  logic                                                fill_valid;
  logic [`MEM_LINE_WIDTH-1:0]                          fill_data;   // Word 0 in the low bits.
  logic [`MEM_LINE_IDX_WIDTH-1:0]                      fill_line;
  logic                                                busy;
  logic                                                done;
  logic [`MEM_LINE_WORDS-1:0][`MEM_WORD_WIDTH-1:0]     fill_words;  // Captured copy of the line.
  logic [`MEM_LINE_IDX_WIDTH-1:0]                      cap_line;    // Line index of last capture.

  modport source (
    output fill_valid,
    output fill_data,
    output fill_line
  );

  modport sink (
    input  fill_valid,
    input  fill_data,
    input  fill_line,
    output busy,
    output done,
    output fill_words,
    output cap_line
  );

  modport status (
    input busy,
    input done,
    input fill_words,
    input cap_line
  );

endinterface

// File: verilog/line_memory.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module line_memory import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  mem_req_if.slave  req,
  fill_if.source    fill
);

  localparam int WORD_SEL_WIDTH = $clog2(`MEM_LINE_WORDS);
  localparam int DEPTH          = `MEM_TRANSFER_TIME;

  logic [`MEM_WORD_WIDTH-1:0]     mem [`MEM_WORDS];
  logic [`MEM_LINE_IDX_WIDTH-1:0] line_idx;
  logic [`MEM_LINE_WIDTH-1:0]     line_data;
  logic                           fill_req;
  logic                           store_req;

  logic [DEPTH-1:0]               valid_pipe;
  logic [`MEM_LINE_WIDTH-1:0]     data_pipe [DEPTH];
  logic [`MEM_LINE_IDX_WIDTH-1:0] line_pipe [DEPTH];

  assign store_req = req.req && (req.op == MEM_OP_STORE);
  assign fill_req  = req.req && (req.op == MEM_OP_FILL);

  // Word storage, written one word per store request.
  always_ff @(posedge clk) begin
    if (store_req) mem[req.addr] <= req.store_data;
  end

  assign line_idx = req.addr[`MEM_ADDR_WIDTH-1:WORD_SEL_WIDTH];

  // Read sees the array before a store on the same edge.
  always_comb begin
    for (int w = 0; w < `MEM_LINE_WORDS; w++) begin
      line_data[w*`MEM_WORD_WIDTH +: `MEM_WORD_WIDTH] =
        mem[{line_idx, w[WORD_SEL_WIDTH-1:0]}];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[DEPTH-2:0], fill_req};
    end
  end

  // Line payload follows the valid bits through the same number of stages.
  always_ff @(posedge clk) begin
    data_pipe[0] <= line_data;
    line_pipe[0] <= line_idx;
    for (int s = 1; s < DEPTH; s++) begin
      data_pipe[s] <= data_pipe[s-1];
      line_pipe[s] <= line_pipe[s-1];
    end
  end

  assign fill.fill_valid = valid_pipe[DEPTH-1];
  assign fill.fill_data  = data_pipe[DEPTH-1];
  assign fill.fill_line  = line_pipe[DEPTH-1];

endmodule

// File: verilog/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Storage geometry of the backing memory.
`define MEM_WORD_WIDTH      32
`define MEM_LINE_WORDS      4
`define MEM_WORDS           64
`define MEM_ADDR_WIDTH      6
`define MEM_LINE_WIDTH      (`MEM_WORD_WIDTH * `MEM_LINE_WORDS)
`define MEM_LINE_IDX_WIDTH  ($clog2(`MEM_WORDS / `MEM_LINE_WORDS))

`define MEM_TRANSFER_TIME   5  // Cycles from fill request to returned line.

`define APB_ADDR_WIDTH      8

// Register map as byte offsets on PADDR.
`define REG_ADDR            8'h00
`define REG_STORE           8'h04
`define REG_FILL            8'h08
`define REG_STATUS          8'h0C
`define REG_FILL_WORD0      8'h10

`endif

// File: verilog/mem_pkg.sv
package mem_pkg;

  // Request kinds sent from the APB port to the line memory.
  typedef enum logic {
    MEM_OP_STORE = 1'b0,  // Write one word at the request address.
    MEM_OP_FILL  = 1'b1   // Return the line that holds the request address.
  } mem_op_t;

  // Register selected by the current PADDR.
  typedef enum logic [2:0] {
    SEL_ADDR,
    SEL_STORE,
    SEL_FILL,
    SEL_STATUS,
    SEL_FILL_WORD,  // One of the four captured line words.
    SEL_NONE        // Unmapped or misaligned offset.
  } reg_sel_t;

endpackage

// File: verilog/mem_req_if.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

interface mem_req_if import mem_pkg::*; ();

  logic                       req;         // One-cycle request pulse.
  mem_op_t                    op;
  logic [`MEM_ADDR_WIDTH-1:0] addr;        // Word address.
  logic [`MEM_WORD_WIDTH-1:0] store_data;  // Only meaningful for stores.

  modport master (
    output req,
    output op,
    output addr,
    output store_data
  );

  modport slave (
    input req,
    input op,
    input addr,
    input store_data
  );

  // The fill buffer only needs to see when a fill starts.
  modport monitor (
    input req,
    input op
  );

endinterface

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_subsys_top (
  input  logic                       pclk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [`APB_ADDR_WIDTH-1:0] paddr,
  input  logic [`MEM_WORD_WIDTH-1:0] pwdata,
  output logic [`MEM_WORD_WIDTH-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr
);

  mem_req_if u_req_if ();  // Commands from the APB port.
  fill_if    u_fill_if (); // Returned lines and fill status.

  apb_mem_port u_apb_mem_port (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .req     (u_req_if.master),
    .stat    (u_fill_if.status)
  );

  line_memory u_line_memory (
    .clk   (pclk),
    .rst_n (rst_n),
    .req   (u_req_if.slave),
    .fill  (u_fill_if.source)
  );

  fill_buffer u_fill_buffer (
    .clk   (pclk),
    .rst_n (rst_n),
    .mon   (u_req_if.monitor),
    .fill  (u_fill_if.sink)
  );

endmodule
